// File: src/cache_pkg.sv
// Data cache shared definitions
package cache_pkg;

    // ------------------------------------------------------------
    // Line geometry.
    // ------------------------------------------------------------
    localparam int LINE_BYTES  = 64;
    localparam int LINE_W      = LINE_BYTES * 8;
    localparam int LINE_OFF_W  = $clog2(LINE_BYTES);
    localparam int DWORD_W     = 64;
    localparam int DWORD_SEL_W = $clog2(LINE_W / DWORD_W);

    // ------------------------------------------------------------
    // Request encodings.
    // ------------------------------------------------------------
    typedef enum logic [1:0] {
        OP_LOAD   = 2'd0,
        OP_STORE  = 2'd1,
        OP_REFILL = 2'd2
    } cache_op_e;

    // Same codes as the core's store type field.
    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2,
        SIZE_D = 2'd3
    } store_size_e;

endpackage

// File: src/cache_req_front.sv
// Cache request front end
`timescale 1ns/1ps

module cache_req_front import cache_pkg::*; #(
    parameter int ADDR_WIDTH = 32,
    parameter int SET_COUNT  = 16,
    localparam int INDEX_W   = $clog2(SET_COUNT),
    localparam int TAG_W     = ADDR_WIDTH - INDEX_W - LINE_OFF_W
) (
    input  logic                   clk,
    input  logic                   arstn,
    input  logic                   i_req,
    input  logic                   i_ack_state,
    input  cache_op_e              i_op,
    input  store_size_e            i_size,
    input  logic [ADDR_WIDTH-1:0]  i_addr,
    input  logic [DWORD_W-1:0]     i_wdata,
    input  logic [LINE_W-1:0]      i_line,
    output logic                   o_go,
    output cache_op_e              o_op,
    output store_size_e            o_size,
    output logic [INDEX_W-1:0]     o_index,
    output logic [TAG_W-1:0]       o_tag,
    output logic [DWORD_SEL_W-1:0] o_dword_sel,
    output logic [2:0]             o_byte_off,
    output logic [DWORD_W-1:0]     o_wdata,
    output logic [LINE_W-1:0]      o_line
);

    logic                  busy_q;
    logic                  capture;
    logic [ADDR_WIDTH-1:0] addr_q;

    // New request only when idle and the previous ack is gone.
    assign capture = i_req && !i_ack_state && !busy_q;

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            busy_q <= 1'b0;
            o_go   <= 1'b0;
        end else begin
            o_go <= capture;
            if (capture) begin
                busy_q <= 1'b1;
            end else if (i_ack_state) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            o_op    <= i_op;
            o_size  <= i_size;
            addr_q  <= i_addr;
            o_wdata <= i_wdata;
            o_line  <= i_line;
        end
    end

    // ------------------------------------------------------------
    // Address split.
    // ------------------------------------------------------------
    assign o_tag       = addr_q[ADDR_WIDTH-1 -: TAG_W];
    assign o_index     = addr_q[LINE_OFF_W +: INDEX_W];
    assign o_dword_sel = addr_q[3 +: DWORD_SEL_W];
    assign o_byte_off  = addr_q[2:0];

endmodule

// File: src/cache_way_ram.sv
// Set and way storage array
`timescale 1ns/1ps

module cache_way_ram #(
    parameter int  SET_COUNT = 16,
    parameter int  WAY_COUNT = 4,
    parameter type payload_t = logic,
    localparam int INDEX_W   = $clog2(SET_COUNT),
    localparam int WAY_W     = $clog2(WAY_COUNT)
) (
    input  logic               clk,
    input  logic               i_we,
    input  logic [WAY_W-1:0]   i_wr_way,
    input  logic [INDEX_W-1:0] i_index,
    input  payload_t           i_wr_data,
    input  logic [WAY_W-1:0]   i_rd_way,
    output payload_t           o_rd_data,
    output payload_t           o_all_ways [WAY_COUNT]
);

    payload_t mem_q [SET_COUNT][WAY_COUNT];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem_q[i_index][i_wr_way] <= i_wr_data;
        end
    end

    assign o_rd_data = mem_q[i_index][i_rd_way];

    // Whole set, for parallel compare or victim pick.
    always_comb begin
        for (int w = 0; w < WAY_COUNT; w++) begin
            o_all_ways[w] = mem_q[i_index][w];
        end
    end

endmodule

// File: src/cache_tag_lru.sv
// Tag state and LRU control
`timescale 1ns/1ps

module cache_tag_lru import cache_pkg::*; #(
    parameter int ADDR_WIDTH = 32,
    parameter int SET_COUNT  = 16,
    parameter int WAY_COUNT  = 4,
    localparam int INDEX_W   = $clog2(SET_COUNT),
    localparam int WAY_W     = $clog2(WAY_COUNT),
    localparam int TAG_W     = ADDR_WIDTH - INDEX_W - LINE_OFF_W
) (
    input  logic               clk,
    input  logic               arstn,
    input  logic               i_go,
    input  cache_op_e          i_op,
    input  store_size_e        i_size,
    input  logic [2:0]         i_byte_off,
    input  logic [INDEX_W-1:0] i_index,
    input  logic [TAG_W-1:0]   i_tag,
    input  logic [TAG_W-1:0]   i_set_tags [WAY_COUNT],
    output logic               o_hit,
    output logic [WAY_W-1:0]   o_hit_way,
    output logic [WAY_W-1:0]   o_victim_way,
    output logic               o_victim_dirty,
    output logic               o_misalign,
    output logic               o_tag_we,
    output logic               o_line_we,
    output logic [WAY_W-1:0]   o_line_way
);

    localparam logic [WAY_W-1:0] RANK_TOP = WAY_W'(WAY_COUNT - 1);

    logic [WAY_COUNT-1:0] valid_q [SET_COUNT];
    logic [WAY_COUNT-1:0] dirty_q [SET_COUNT];
    logic [WAY_W-1:0]     rank_q  [SET_COUNT][WAY_COUNT];

    logic [WAY_COUNT-1:0] hit_vec;
    logic                 is_refill;
    logic                 store_ok;
    logic [WAY_W-1:0]     acc_way;

    // ------------------------------------------------------------
    // Lookup.
    // ------------------------------------------------------------
    always_comb begin
        o_hit_way    = '0;
        o_victim_way = '0;
        for (int w = 0; w < WAY_COUNT; w++) begin
            hit_vec[w] = valid_q[i_index][w] && (i_set_tags[w] == i_tag);
        end
        // Lowest matching way wins.
        for (int w = WAY_COUNT - 1; w >= 0; w--) begin
            if (hit_vec[w]) begin
                o_hit_way = WAY_W'(w);
            end
            if (rank_q[i_index][w] == '0) begin
                o_victim_way = WAY_W'(w);
            end
        end
    end

    assign o_hit          = |hit_vec;
    assign o_victim_dirty = dirty_q[i_index][o_victim_way];

    always_comb begin
        case (i_size)
            SIZE_H:  o_misalign = i_byte_off[0];
            SIZE_W:  o_misalign = |i_byte_off[1:0];
            SIZE_D:  o_misalign = |i_byte_off;
            default: o_misalign = 1'b0;
        endcase
        if (i_op != OP_STORE) begin
            o_misalign = 1'b0;
        end
    end

    // ------------------------------------------------------------
    // Write enables.
    // ------------------------------------------------------------
    assign is_refill  = (i_op == OP_REFILL);
    assign store_ok   = (i_op == OP_STORE) && o_hit && !o_misalign;
    assign acc_way    = is_refill ? o_victim_way : o_hit_way;
    assign o_line_way = acc_way;
    assign o_tag_we   = i_go && is_refill;
    assign o_line_we  = i_go && (is_refill || store_ok);

    // ------------------------------------------------------------
    // Valid, dirty and rank state.
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            for (int s = 0; s < SET_COUNT; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                for (int w = 0; w < WAY_COUNT; w++) begin
                    rank_q[s][w] <= WAY_W'(w);
                end
            end
        end else if (i_go) begin
            if (is_refill) begin
                valid_q[i_index][o_victim_way] <= 1'b1;
                dirty_q[i_index][o_victim_way] <= 1'b0;
            end else if (store_ok) begin
                dirty_q[i_index][o_hit_way] <= 1'b1;
            end
            // Accessed way to the top, those above it move down.
            if (is_refill || o_hit) begin
                for (int w = 0; w < WAY_COUNT; w++) begin
                    if (WAY_W'(w) == acc_way) begin
                        rank_q[i_index][w] <= RANK_TOP;
                    end else if (rank_q[i_index][w] > rank_q[i_index][acc_way]) begin
                        rank_q[i_index][w] <= rank_q[i_index][w] - 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: src/cache_store_merge.sv
// Store data line merge
`timescale 1ns/1ps

module cache_store_merge import cache_pkg::*; (
    input  logic [LINE_W-1:0]      i_line,
    input  logic [DWORD_W-1:0]     i_wdata,
    input  store_size_e            i_size,
    input  logic [DWORD_SEL_W-1:0] i_dword_sel,
    input  logic [2:0]             i_byte_off,
    output logic [LINE_W-1:0]      o_line
);

    logic [LINE_OFF_W-1:0] line_off;
    logic [7:0]            size_mask;
    logic [LINE_BYTES-1:0] lane_mask;
    logic [LINE_W-1:0]     lane_data;

    assign line_off = {i_dword_sel, i_byte_off};

    always_comb begin
        case (i_size)
            SIZE_B:  size_mask = 8'h01;
            SIZE_H:  size_mask = 8'h03;
            SIZE_W:  size_mask = 8'h0f;
            default: size_mask = 8'hff;
        endcase
    end

    // Move mask and data onto the addressed byte lanes.
    assign lane_mask = LINE_BYTES'(size_mask) << line_off;
    assign lane_data = LINE_W'(i_wdata) << {line_off, 3'b000};

    always_comb begin
        for (int b = 0; b < LINE_BYTES; b++) begin
            if (lane_mask[b]) begin
                o_line[b*8 +: 8] = lane_data[b*8 +: 8];
            end else begin
                o_line[b*8 +: 8] = i_line[b*8 +: 8];
            end
        end
    end

endmodule

// File: src/cache_resp.sv
// Cache response registers
`timescale 1ns/1ps

module cache_resp import cache_pkg::*; #(
    parameter int ADDR_WIDTH = 32,
    parameter int SET_COUNT  = 16,
    localparam int INDEX_W   = $clog2(SET_COUNT),
    localparam int TAG_W     = ADDR_WIDTH - INDEX_W - LINE_OFF_W
) (
    input  logic                   clk,
    input  logic                   arstn,
    input  logic                   i_go,
    input  logic                   i_req,
    input  logic                   i_hit,
    input  logic                   i_misalign,
    input  logic [LINE_W-1:0]      i_hit_line,
    input  logic [DWORD_SEL_W-1:0] i_dword_sel,
    input  logic                   i_victim_dirty,
    input  logic [TAG_W-1:0]       i_victim_tag,
    input  logic [INDEX_W-1:0]     i_index,
    input  logic [LINE_W-1:0]      i_victim_line,
    output logic                   o_ack,
    output logic                   o_hit,
    output logic                   o_misalign,
    output logic [DWORD_W-1:0]     o_rdata,
    output logic                   o_victim_dirty,
    output logic [ADDR_WIDTH-1:0]  o_wb_addr,
    output logic [LINE_W-1:0]      o_wb_line
);

    logic                  go_d;
    logic                  hit_s;
    logic                  misalign_s;
    logic                  dirty_s;
    logic [DWORD_W-1:0]    rdata_s;
    logic [ADDR_WIDTH-1:0] wb_addr_s;
    logic [LINE_W-1:0]     wb_line_s;

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            go_d  <= 1'b0;
            o_ack <= 1'b0;
        end else begin
            go_d <= i_go;
            if (go_d) begin
                o_ack <= 1'b1;
            end else if (!i_req) begin
                o_ack <= 1'b0;
            end
        end
    end

    // Snapshot taken before the request's own write lands.
    always_ff @(posedge clk) begin
        if (i_go) begin
            hit_s      <= i_hit;
            misalign_s <= i_misalign;
            dirty_s    <= i_victim_dirty;
            rdata_s    <= i_hit_line[i_dword_sel*DWORD_W +: DWORD_W];
            wb_addr_s  <= {i_victim_tag, i_index, {LINE_OFF_W{1'b0}}};
            wb_line_s  <= i_victim_line;
        end
        if (go_d) begin
            o_hit          <= hit_s;
            o_misalign     <= misalign_s;
            o_victim_dirty <= dirty_s;
            o_rdata        <= rdata_s;
            o_wb_addr      <= wb_addr_s;
            o_wb_line      <= wb_line_s;
        end
    end

endmodule

// File: src/data_cache_top.sv
// Set-associative data cache
`timescale 1ns/1ps

module data_cache_top import cache_pkg::*; #(
    parameter int ADDR_WIDTH = 32,
    parameter int SET_COUNT  = 16,
    parameter int WAY_COUNT  = 4
) (
    input  logic                  clk,
    input  logic                  arstn,
    input  logic                  i_req,
    input  cache_op_e             i_op,
    input  store_size_e           i_size,
    input  logic [ADDR_WIDTH-1:0] i_addr,
    input  logic [DWORD_W-1:0]    i_wdata,
    input  logic [LINE_W-1:0]     i_line,
    output logic                  o_ack,
    output logic                  o_hit,
    output logic                  o_misalign,
    output logic [DWORD_W-1:0]    o_rdata,
    output logic                  o_victim_dirty,
    output logic [ADDR_WIDTH-1:0] o_wb_addr,
    output logic [LINE_W-1:0]     o_wb_line
);

    localparam int INDEX_W = $clog2(SET_COUNT);
    localparam int WAY_W   = $clog2(WAY_COUNT);
    localparam int TAG_W   = ADDR_WIDTH - INDEX_W - LINE_OFF_W;

    typedef logic [TAG_W-1:0]  tag_t;
    typedef logic [LINE_W-1:0] line_t;

    logic                   go;
    cache_op_e              op;
    store_size_e            size;
    logic [INDEX_W-1:0]     index;
    logic [TAG_W-1:0]       tag;
    logic [DWORD_SEL_W-1:0] dword_sel;
    logic [2:0]             byte_off;
    logic [DWORD_W-1:0]     wdata;
    logic [LINE_W-1:0]      req_line;

    logic                   hit;
    logic [WAY_W-1:0]       hit_way;
    logic [WAY_W-1:0]       victim_way;
    logic                   victim_dirty;
    logic                   misalign;
    logic                   tag_we;
    logic                   line_we;
    logic [WAY_W-1:0]       line_way;

    tag_t                   victim_tag;
    tag_t                   set_tags [WAY_COUNT];
    line_t                  hit_line;
    line_t                  set_lines [WAY_COUNT];
    line_t                  victim_line;
    line_t                  merged_line;
    line_t                  line_wr_data;

    assign victim_line  = set_lines[victim_way];
    assign line_wr_data = (op == OP_REFILL) ? req_line : merged_line;

    // ------------------------------------------------------------
    // Input side.
    // ------------------------------------------------------------
    cache_req_front #(.ADDR_WIDTH(ADDR_WIDTH), .SET_COUNT(SET_COUNT)) u_front (
        .clk(clk), .arstn(arstn), .i_req(i_req), .i_ack_state(o_ack),
        .i_op(i_op), .i_size(i_size), .i_addr(i_addr), .i_wdata(i_wdata),
        .i_line(i_line), .o_go(go), .o_op(op), .o_size(size), .o_index(index),
        .o_tag(tag), .o_dword_sel(dword_sel), .o_byte_off(byte_off),
        .o_wdata(wdata), .o_line(req_line)
    );

    // ------------------------------------------------------------
    // Lookup and storage.
    // ------------------------------------------------------------
    cache_tag_lru #(
        .ADDR_WIDTH(ADDR_WIDTH), .SET_COUNT(SET_COUNT), .WAY_COUNT(WAY_COUNT)
    ) u_tag_lru (
        .clk(clk), .arstn(arstn), .i_go(go), .i_op(op), .i_size(size),
        .i_byte_off(byte_off), .i_index(index), .i_tag(tag), .i_set_tags(set_tags),
        .o_hit(hit), .o_hit_way(hit_way), .o_victim_way(victim_way),
        .o_victim_dirty(victim_dirty), .o_misalign(misalign), .o_tag_we(tag_we),
        .o_line_we(line_we), .o_line_way(line_way)
    );

    // Tags are only written by a refill, into the victim way.
    cache_way_ram #(.SET_COUNT(SET_COUNT), .WAY_COUNT(WAY_COUNT), .payload_t(tag_t)) u_tag_ram (
        .clk(clk), .i_we(tag_we), .i_wr_way(victim_way), .i_index(index),
        .i_wr_data(tag), .i_rd_way(victim_way), .o_rd_data(victim_tag),
        .o_all_ways(set_tags)
    );

    cache_way_ram #(.SET_COUNT(SET_COUNT), .WAY_COUNT(WAY_COUNT), .payload_t(line_t)) u_line_ram (
        .clk(clk), .i_we(line_we), .i_wr_way(line_way), .i_index(index),
        .i_wr_data(line_wr_data), .i_rd_way(hit_way), .o_rd_data(hit_line),
        .o_all_ways(set_lines)
    );

    cache_store_merge u_merge (
        .i_line(hit_line), .i_wdata(wdata), .i_size(size),
        .i_dword_sel(dword_sel), .i_byte_off(byte_off), .o_line(merged_line)
    );

    // ------------------------------------------------------------
    // Output side.
    // ------------------------------------------------------------
    cache_resp #(.ADDR_WIDTH(ADDR_WIDTH), .SET_COUNT(SET_COUNT)) u_resp (
        .clk(clk), .arstn(arstn), .i_go(go), .i_req(i_req), .i_hit(hit),
        .i_misalign(misalign), .i_hit_line(hit_line), .i_dword_sel(dword_sel),
        .i_victim_dirty(victim_dirty), .i_victim_tag(victim_tag), .i_index(index),
        .i_victim_line(victim_line), .o_ack(o_ack), .o_hit(o_hit),
        .o_misalign(o_misalign), .o_rdata(o_rdata), .o_victim_dirty(o_victim_dirty),
        .o_wb_addr(o_wb_addr), .o_wb_line(o_wb_line)
    );

endmodule

// File: dv/data_cache_assert.sv
// Data cache handshake checks
`timescale 1ns/1ps

module data_cache_assert import cache_pkg::*; (
    input logic        clk,
    input logic        arstn,
    input logic        i_req,
    input logic        i_ack,
    input logic        i_misalign,
    input store_size_e i_size
);

    int fail_count = 0;

    // Ack only answers a raised request.
    ack_needs_req: assert property (@(posedge clk) disable iff (!arstn)
        $rose(i_ack) |-> $past(i_req))
        else begin
            fail_count++;
            $error("o_ack rose while i_req was low");
        end

    ack_drop_after_req: assert property (@(posedge clk) disable iff (!arstn)
        $fell(i_ack) |-> !$past(i_req))
        else begin
            fail_count++;
            $error("o_ack fell while i_req was still high");
        end

    // A byte access can never be misaligned.
    byte_never_misaligned: assert property (@(posedge clk) disable iff (!arstn)
        (i_ack && i_misalign) |-> (i_size != SIZE_B))
        else begin
            fail_count++;
            $error("o_misalign set for a byte store");
        end

endmodule

bind data_cache_top data_cache_assert u_assert (
    .clk(clk), .arstn(arstn), .i_req(i_req), .i_ack(o_ack),
    .i_misalign(o_misalign), .i_size(size)
);

// File: dv/tb_data_cache.sv
// Data cache testbench
`timescale 1ns/1ps

module tb_data_cache import cache_pkg::*; ();

    typedef struct {
        cache_op_e   op;
        store_size_e size;
        logic [31:0] addr;
        logic [63:0] wdata;
        int          lidx;
        int          hold;
        logic        hit;
        logic        mis;
        logic        dirty;
        logic [31:0] wb_addr;
        int          vidx;
    } row_t;

    logic               clk;
    logic               arstn;
    logic               i_req;
    cache_op_e          i_op;
    store_size_e        i_size;
    logic [31:0]        i_addr;
    logic [DWORD_W-1:0] i_wdata;
    logic [LINE_W-1:0]  i_line;
    logic               o_ack;
    logic               o_hit;
    logic               o_misalign;
    logic [DWORD_W-1:0] o_rdata;
    logic               o_victim_dirty;
    logic [31:0]        o_wb_addr;
    logic [LINE_W-1:0]  o_wb_line;

    row_t              rows [$];
    logic [LINE_W-1:0] lines [5];
    integer            seed;
    int                row_num = 0;
    int                cycles = 0;
    int                limit = 0;

    data_cache_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Run length guard.
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout: the DUT did not finish within %0d cycles", limit);
            $display("=== FAIL ===");
            $fatal(1, "Run stopped by timeout");
        end
    end

    task automatic compare_value(input string name, input logic [LINE_W-1:0] got,
                                 input logic [LINE_W-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s in row %0d: got 0x%0h, expected 0x%0h",
                     name, row_num, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "Stopped at first error");
        end
    endtask

    task automatic add_row(input cache_op_e op, input store_size_e size,
                           input logic [31:0] addr, input logic [63:0] wdata,
                           input int lidx, input int hold, input logic hit,
                           input logic mis, input logic dirty,
                           input logic [31:0] wb_addr, input int vidx);
        rows.push_back('{op, size, addr, wdata, lidx, hold, hit, mis, dirty, wb_addr, vidx});
    endtask

    // Reference byte replacement for an aligned store hit.
    function automatic logic [LINE_W-1:0] merge_store(input logic [LINE_W-1:0] line,
                                                      input row_t r);
        int base;
        base = int'(r.addr[5:0]);
        for (int i = 0; i < (1 << r.size); i++) begin
            line[(base + i) * 8 +: 8] = r.wdata[i * 8 +: 8];
        end
        return line;
    endfunction

    // ------------------------------------------------------------
    // Stimulus table.
    // op, size, addr, wdata, line, hold, hit, misalign, dirty, wb addr, wb line
    // ------------------------------------------------------------
    task automatic fill_table();
        // Empty set, refill, then every doubleword.
        add_row(OP_LOAD,   SIZE_D, 32'h00000440, 64'h0, 0, 0, 0, 0, 0, 32'h0, 0);
        add_row(OP_REFILL, SIZE_D, 32'h00000440, 64'h0, 0, 0, 0, 0, 0, 32'h0, 0);
        add_row(OP_LOAD,   SIZE_D, 32'h00000440, 64'h0, 0, 0, 1, 0, 0, 32'h0, 0);
        add_row(OP_LOAD,   SIZE_D, 32'h00000448, 64'h0, 0, 0, 1, 0, 0, 32'h0, 0);
        add_row(OP_LOAD,   SIZE_D, 32'h00000450, 64'h0, 0, 0, 1, 0, 0, 32'h0, 0);
        add_row(OP_LOAD,   SIZE_D, 32'h00000458, 64'h0, 0, 0, 1, 0, 0, 32'h0, 0);
        add_row(OP_LOAD,   SIZE_D, 32'h00000460, 64'h0, 0, 0, 1, 0, 0, 32'h0, 0);
        add_row(OP_LOAD,   SIZE_D, 32'h00000468, 64'h0, 0, 0, 1, 0, 0, 32'h0, 0);
        add_row(OP_LOAD,   SIZE_D, 32'h00000470, 64'h0, 0, 0, 1, 0, 0, 32'h0, 0);
        add_row(OP_LOAD,   SIZE_D, 32'h00000478, 64'h0, 0, 0, 1, 0, 0, 32'h0, 0);
        // Aligned stores of each size.
        add_row(OP_STORE,  SIZE_B, 32'h00000443, 64'hffeeddccbbaa99a5, 0, 0, 1, 0, 0, 32'h0, 0);
        add_row(OP_STORE,  SIZE_H, 32'h0000044a, 64'h1122334455667788, 0, 0, 1, 0, 0, 32'h0, 0);
        add_row(OP_STORE,  SIZE_W, 32'h00000454, 64'hcafef00d12345678, 0, 0, 1, 0, 0, 32'h0, 0);
        add_row(OP_STORE,  SIZE_D, 32'h00000458, 64'h0123456789abcdef, 0, 0, 1, 0, 0, 32'h0, 0);
        add_row(OP_LOAD,   SIZE_D, 32'h00000440, 64'h0, 0, 0, 1, 0, 0, 32'h0, 0);
        add_row(OP_LOAD,   SIZE_D, 32'h00000448, 64'h0, 0, 0, 1, 0, 0, 32'h0, 0);
        add_row(OP_LOAD,   SIZE_D, 32'h00000450, 64'h0, 0, 0, 1, 0, 0, 32'h0, 0);
        add_row(OP_LOAD,   SIZE_D, 32'h00000458, 64'h0, 0, 0, 1, 0, 0, 32'h0, 0);
        // Misaligned stores.
        add_row(OP_STORE,  SIZE_H, 32'h00000461, 64'h5555, 0, 0, 1, 1, 0, 32'h0, 0);
        add_row(OP_STORE,  SIZE_W, 32'h0000046a, 64'h66666666, 0, 0, 1, 1, 0, 32'h0, 0);
        add_row(OP_STORE,  SIZE_D, 32'h00000474, 64'h7777777777777777, 0, 0, 1, 1, 0, 32'h0, 0);
        add_row(OP_LOAD,   SIZE_D, 32'h00000460, 64'h0, 0, 0, 1, 0, 0, 32'h0, 0);
        add_row(OP_LOAD,   SIZE_D, 32'h00000468, 64'h0, 0, 0, 1, 0, 0, 32'h0, 0);
        add_row(OP_LOAD,   SIZE_D, 32'h00000470, 64'h0, 0, 0, 1, 0, 0, 32'h0, 0);
        // Fill set 1 until the dirty line is the LRU victim.
        add_row(OP_REFILL, SIZE_D, 32'h00000840, 64'h0, 1, 0, 0, 0, 0, 32'h0, 0);
        add_row(OP_LOAD,   SIZE_D, 32'h00000440, 64'h0, 0, 0, 1, 0, 0, 32'h0, 0);
        add_row(OP_REFILL, SIZE_D, 32'h00000c40, 64'h0, 2, 0, 0, 0, 0, 32'h0, 0);
        add_row(OP_LOAD,   SIZE_D, 32'h00000848, 64'h0, 1, 0, 1, 0, 0, 32'h0, 0);
        add_row(OP_REFILL, SIZE_D, 32'h00001040, 64'h0, 3, 0, 0, 0, 0, 32'h0, 0);
        add_row(OP_LOAD,   SIZE_D, 32'h00000c50, 64'h0, 2, 4, 1, 0, 1, 32'h440, 0);
        add_row(OP_REFILL, SIZE_D, 32'h00001440, 64'h0, 4, 0, 0, 0, 1, 32'h440, 0);
        add_row(OP_LOAD,   SIZE_D, 32'h00001478, 64'h0, 4, 2, 1, 0, 0, 32'h0, 0);
        // Misses to an absent tag.
        add_row(OP_STORE,  SIZE_D, 32'h00007c40, 64'hdeadbeefdeadbeef, 0, 0, 0, 0, 0, 32'h0, 0);
        add_row(OP_LOAD,   SIZE_D, 32'h00007c40, 64'h0, 0, 0, 0, 0, 0, 32'h0, 0);
        add_row(OP_LOAD,   SIZE_D, 32'h00001440, 64'h0, 4, 0, 1, 0, 0, 32'h0, 0);
    endtask

    // One full four-phase handshake.
    task automatic run_row(input row_t r);
        logic [DWORD_W-1:0] exp_rdata;
        logic [DWORD_W-1:0] held_rdata;
        logic [LINE_W-1:0]  held_line;
        int                 waited;
        exp_rdata = lines[r.lidx][r.addr[5:3] * 64 +: 64];
        i_op      = r.op;
        i_size    = r.size;
        i_addr    = r.addr;
        i_wdata   = r.wdata;
        i_line    = lines[r.lidx];
        i_req     = 1'b1;
        waited    = 0;
        do begin
            @(posedge clk);
            #2;
            waited++;
        end while (!o_ack);
        compare_value("ack_latency", waited, 3);
        compare_value("o_hit", o_hit, r.hit);
        compare_value("o_misalign", o_misalign, r.mis);
        compare_value("o_victim_dirty", o_victim_dirty, r.dirty);
        if (r.hit) begin
            compare_value("o_rdata", o_rdata, exp_rdata);
        end
        if (r.dirty) begin
            compare_value("o_wb_addr", o_wb_addr, r.wb_addr);
            compare_value("o_wb_line", o_wb_line, lines[r.vidx]);
        end
        held_rdata = o_rdata;
        held_line  = o_wb_line;
        repeat (r.hold) begin
            @(posedge clk);
            #2;
            compare_value("o_ack", o_ack, 1'b1);
            compare_value("o_hit", o_hit, r.hit);
            compare_value("o_misalign", o_misalign, r.mis);
            compare_value("o_victim_dirty", o_victim_dirty, r.dirty);
            compare_value("o_rdata", o_rdata, held_rdata);
            compare_value("o_wb_line", o_wb_line, held_line);
        end
        i_req = 1'b0;
        @(posedge clk);
        #2;
        compare_value("o_ack", o_ack, 1'b0);
        if (r.op == OP_STORE && r.hit && !r.mis) begin
            lines[r.lidx] = merge_store(lines[r.lidx], r);
        end
    endtask

    initial begin
        int max_hold;
        arstn   = 1'b0;
        i_req   = 1'b0;
        i_op    = OP_LOAD;
        i_size  = SIZE_B;
        i_addr  = '0;
        i_wdata = '0;
        i_line  = '0;
        seed    = 46;
        for (int n = 0; n < 5; n++) begin
            for (int k = 0; k < 16; k++) begin
                lines[n][k * 32 +: 32] = $random(seed);
            end
        end
        fill_table();
        max_hold = 0;
        foreach (rows[n]) begin
            if (rows[n].hold > max_hold) begin
                max_hold = rows[n].hold;
            end
        end
        limit = rows.size() * (6 + max_hold) + 3;
        repeat (3) @(posedge clk);
        #2;
        arstn = 1'b1;
        compare_value("o_ack", o_ack, 1'b0);
        foreach (rows[n]) begin
            row_num = n;
            run_row(rows[n]);
        end
        compare_value("assertion_failures", UUT.u_assert.fail_count, 0);
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: project.f
src/cache_pkg.sv
src/cache_req_front.sv
src/cache_way_ram.sv
src/cache_tag_lru.sv
src/cache_store_merge.sv
src/cache_resp.sv
src/data_cache_top.sv
dv/data_cache_assert.sv
dv/tb_data_cache.sv

// File: Makefile
# Verilator flow for the data cache.
VERILATOR ?= verilator
TOP       ?= tb_data_cache
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
